//--- Makefile
TOP := tb_cent_ctrl

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- cent_ctrl.sv
`timescale 1ns/1ps
// central controller top, sdram init and readback check followed by accelerator tile sequencing
module cent_ctrl
	import cnn_pkg::*;
#(
	parameter int WEIGHT_BASE = 8,
	parameter int IMG_BASE    = 24,
	parameter int IFM_SIZE    = 16,
	parameter int M           = 4,
	parameter int N           = 4,
	parameter int TM          = 2,
	parameter int TN          = 2
) (
	input  logic        clk,
	input  logic        reset_n,

	// memory calibration status
	input  logic        mem_cal_success,
	input  logic        mem_cal_fail,

	// sdram avalon master
	input  logic        avl_ready,
	output logic        avl_burstbegin,
	output sdram_addr_t avl_addr,
	input  logic        avl_rdata_valid,
	input  sdram_data_t avl_rdata,
	output sdram_data_t avl_wdata,
	output logic [7:0]  avl_be,
	output logic        avl_read_req,
	output logic        avl_write_req,
	output logic        avl_size,

	// pio master to the accelerator
	output logic [4:0]  fpga_address,
	output logic        fpga_write_n,
	output pio_data_t   fpga_writedata,
	output logic        fpga_chipselect,
	input  pio_data_t   fpga_readdata,

	input  logic        host_load_done,
	output logic        load_done,
	output logic        fail,
	output logic        compute_done
);

	localparam int OUT_BASE = IMG_BASE + 3 * IFM_SIZE;   // end of three image channels

	sdram_init_seq #(
		.WEIGHT_BASE (WEIGHT_BASE),
		.IMG_BASE    (IMG_BASE),
		.IFM_SIZE    (IFM_SIZE),
		.OUT_BASE    (OUT_BASE)
	) sdram_init_seq_inst (
		.clk             (clk),
		.reset_n         (reset_n),
		.mem_cal_success (mem_cal_success),
		.mem_cal_fail    (mem_cal_fail),
		.avl_ready       (avl_ready),
		.load_done       (load_done),
		.avl_addr        (avl_addr),
		.avl_wdata       (avl_wdata),
		.avl_write_req   (avl_write_req),
		.avl_read_req    (avl_read_req),
		.avl_burstbegin  (avl_burstbegin),
		.avl_be          (avl_be),
		.avl_size        (avl_size)
	);

	init_pattern_checker #(
		.WEIGHT_BASE (WEIGHT_BASE),
		.IMG_BASE    (IMG_BASE),
		.IFM_SIZE    (IFM_SIZE),
		.OUT_BASE    (OUT_BASE)
	) init_pattern_checker_inst (
		.clk             (clk),
		.reset_n         (reset_n),
		.avl_rdata_valid (avl_rdata_valid),
		.avl_rdata       (avl_rdata),
		.load_done       (load_done),
		.fail            (fail)
	);

	tile_sequencer #(
		.M  (M),
		.N  (N),
		.TM (TM),
		.TN (TN)
	) tile_sequencer_inst (
		.clk             (clk),
		.reset_n         (reset_n),
		.load_done       (load_done),
		.host_load_done  (host_load_done),
		.fpga_readdata   (fpga_readdata),
		.fpga_address    (fpga_address),
		.fpga_write_n    (fpga_write_n),
		.fpga_writedata  (fpga_writedata),
		.fpga_chipselect (fpga_chipselect),
		.compute_done    (compute_done)
	);

endmodule

//--- cent_ctrl_sva.sv
`timescale 1ns/1ps
// bound assertions on the avalon and pio outputs and the status levels of the controller top
module cent_ctrl_sva (
	input logic clk,
	input logic reset_n,
	input logic avl_read_req,
	input logic avl_write_req,
	input logic fpga_write_n,
	input logic load_done,
	input logic fail,
	input logic compute_done
);

	a_no_rw_overlap: assert property (@(posedge clk) disable iff (!reset_n)
		!(avl_read_req && avl_write_req))
		else $error("avalon read and write requested in the same cycle");

	a_pio_write_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		!fpga_write_n |=> fpga_write_n)
		else $error("pio write strobe low for more than one cycle");

	// status levels only clear in reset
	a_fail_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		fail |=> fail)
		else $error("fail dropped outside reset");

	a_load_done_held: assert property (@(posedge clk) disable iff (!reset_n)
		load_done |=> load_done)
		else $error("load_done dropped outside reset");

	a_compute_done_held: assert property (@(posedge clk) disable iff (!reset_n)
		compute_done |=> compute_done)
		else $error("compute_done dropped outside reset");

endmodule

bind cent_ctrl cent_ctrl_sva cent_ctrl_sva_inst (
	.clk          (clk),
	.reset_n      (reset_n),
	.avl_read_req (avl_read_req),
	.avl_write_req(avl_write_req),
	.fpga_write_n (fpga_write_n),
	.load_done    (load_done),
	.fail         (fail),
	.compute_done (compute_done)
);

//--- cnn_pkg.sv
// shared types, message codes and the sdram init pattern, imported by every controller module
package cnn_pkg;

	// ====================
	// bus and counter widths
	// ====================
	typedef logic [24:0] sdram_addr_t;   // sdram word address
	typedef logic [63:0] sdram_data_t;   // sdram data word
	typedef logic [31:0] pio_data_t;     // pio bus word
	typedef logic [7:0]  tile_count_t;   // m / n tile counters

	// messages exchanged with the accelerator over the pio registers
	typedef enum logic [7:0] {
		MSG_NONE         = 8'd0,
		MSG_START        = 8'd1,
		MSG_CHECK_IFM    = 8'd2,
		MSG_CHECK_WEIGHT = 8'd3,
		MSG_CHECK_OFM    = 8'd4,
		MSG_CHECK_RESULT = 8'd5,
		MSG_CHECK_WB     = 8'd6
	} cc_msg_t;

	// sdram init sequencer states
	typedef enum logic [1:0] {
		INIT_WAIT,    // waiting for calibration
		INIT_WRITE,   // pattern write pass
		INIT_CHECK,   // readback pass
		INIT_DONE
	} init_state_t;

	// ====================
	// init pattern
	// ====================
	// bias region holds its own address, weights are all ones,
	// image channel c holds its channel-relative index plus c
	function automatic sdram_data_t init_pattern(
		input sdram_addr_t addr,
		input sdram_addr_t weight_base,
		input sdram_addr_t img_base,
		input sdram_addr_t ifm_size
	);
		sdram_data_t a;
		sdram_data_t base;
		sdram_data_t size;
		a = sdram_data_t'(addr);
		base = sdram_data_t'(img_base);
		size = sdram_data_t'(ifm_size);
		if (addr < weight_base)
			return a;                             // bias
		else if (addr < img_base)
			return sdram_data_t'(1);              // weights
		else if (a < base + size)
			return a - base;                      // chan 0
		else if (a < base + 64'd2 * size)
			return a - base - size + 64'd1;       // chan 1
		else
			return a - base - 64'd2 * size + 64'd2;   // chan 2
	endfunction

endpackage

//--- flist.f
cnn_pkg.sv
sdram_init_seq.sv
init_pattern_checker.sv
tile_sequencer.sv
cent_ctrl.sv
sdram_model.sv
cent_ctrl_sva.sv
tb_cent_ctrl.sv

//--- init_pattern_checker.sv
`timescale 1ns/1ps
// compares each returned readback word with the init pattern and reports load done or a sticky fail
module init_pattern_checker
	import cnn_pkg::*;
#(
	parameter int WEIGHT_BASE = 8,
	parameter int IMG_BASE    = 24,
	parameter int IFM_SIZE    = 16,
	parameter int OUT_BASE    = 72
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        avl_rdata_valid,
	input  sdram_data_t avl_rdata,
	output logic        load_done,   // all words passed
	output logic        fail         // sticky, first miscompare
);

	localparam sdram_addr_t LAST_ADDR = sdram_addr_t'(OUT_BASE - 1);

	sdram_addr_t check_count;   // address of the next expected word
	sdram_data_t expected;
	logic        check_en;
	logic        word_ok;

	// reads come back in request order, so the count is the address
	assign expected = init_pattern(check_count, sdram_addr_t'(WEIGHT_BASE),
		sdram_addr_t'(IMG_BASE), sdram_addr_t'(IFM_SIZE));

	assign check_en = avl_rdata_valid && !fail && !load_done;
	assign word_ok  = (avl_rdata == expected);

	// ====================
	// check and count
	// ====================
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			check_count <= '0;
			load_done   <= 1'b0;
			fail        <= 1'b0;
		end else if (check_en) begin
			if (!word_ok) begin
				fail <= 1'b1;   // stop checking here
			end else begin
				check_count <= check_count + 1'b1;
				if (check_count == LAST_ADDR)
					load_done <= 1'b1;
			end
		end
	end

endmodule

//--- sdram_init_seq.sv
`timescale 1ns/1ps
// avalon master driver that writes the init pattern after calibration, then reads it all back
module sdram_init_seq
	import cnn_pkg::*;
#(
	parameter int WEIGHT_BASE = 8,
	parameter int IMG_BASE    = 24,
	parameter int IFM_SIZE    = 16,
	parameter int OUT_BASE    = 72
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        mem_cal_success,
	input  logic        mem_cal_fail,
	input  logic        avl_ready,        // waitrequest_n
	input  logic        load_done,        // from the readback checker
	output sdram_addr_t avl_addr,
	output sdram_data_t avl_wdata,
	output logic        avl_write_req,
	output logic        avl_read_req,
	output logic        avl_burstbegin,
	output logic [7:0]  avl_be,
	output logic        avl_size          // burstcount
);

	localparam sdram_addr_t LAST_ADDR = sdram_addr_t'(OUT_BASE - 1);

	init_state_t state;
	sdram_addr_t addr;          // current request address
	logic        burst_first;   // first cycle of a new request
	logic        rd_issued;     // last readback request accepted
	logic        cal_ok;
	logic        req_accept;

	assign cal_ok = mem_cal_success && !mem_cal_fail;

	// ====================
	// avalon outputs
	// ====================
	assign avl_write_req  = (state == INIT_WRITE);
	assign avl_read_req   = (state == INIT_CHECK) && !rd_issued;
	assign req_accept     = (avl_write_req || avl_read_req) && avl_ready;
	assign avl_addr       = addr;
	assign avl_burstbegin = burst_first;
	assign avl_be         = 8'hff;   // full word writes only
	assign avl_size       = 1'b1;    // single beat bursts

	assign avl_wdata = init_pattern(addr, sdram_addr_t'(WEIGHT_BASE),
		sdram_addr_t'(IMG_BASE), sdram_addr_t'(IFM_SIZE));

	// ====================
	// state machine
	// ====================
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state       <= INIT_WAIT;
			addr        <= '0;
			burst_first <= 1'b0;
			rd_issued   <= 1'b0;
		end else begin
			unique case (state)
				INIT_WAIT: begin
					if (cal_ok) begin
						state       <= INIT_WRITE;
						burst_first <= 1'b1;
					end
				end

				INIT_WRITE: begin
					if (req_accept) begin
						burst_first <= 1'b1;   // next request starts right away
						if (addr == LAST_ADDR) begin
							addr  <= '0;       // readback restarts at word 0
							state <= INIT_CHECK;
						end else begin
							addr <= addr + 1'b1;
						end
					end else begin
						burst_first <= 1'b0;   // stalled, keep request and address
					end
				end

				INIT_CHECK: begin
					if (req_accept) begin
						if (addr == LAST_ADDR) begin
							rd_issued   <= 1'b1;   // all reads out, wait for checker
							burst_first <= 1'b0;
						end else begin
							addr        <= addr + 1'b1;
							burst_first <= 1'b1;
						end
					end else begin
						burst_first <= 1'b0;
					end
					if (load_done)
						state <= INIT_DONE;
				end

				INIT_DONE: begin
					burst_first <= 1'b0;   // memory loaded, bus stays idle
				end

				default: state <= INIT_WAIT;
			endcase
		end
	end

endmodule

//--- sdram_model.sv
`timescale 1ns/1ps
// avalon sdram model for the testbench, with random ready stalls, read latency and word corruption
module sdram_model
	import cnn_pkg::*;
#(
	parameter int DEPTH = 72,
	parameter int SEED  = 9
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        stall_en,       // random ready and read latency
	input  logic        corrupt_en,
	input  sdram_addr_t corrupt_addr,   // word flipped on readback
	input  sdram_addr_t avl_addr,
	input  sdram_data_t avl_wdata,
	input  logic        avl_write_req,
	input  logic        avl_read_req,
	input  logic        avl_burstbegin,
	output logic        avl_ready,
	output logic        avl_rdata_valid,
	output sdram_data_t avl_rdata
);

	sdram_data_t mem [0:DEPTH-1];
	int          write_count [0:DEPTH-1];
	int          read_count [0:DEPTH-1];
	int          burst_count = 0;   // cycles with burstbegin high
	sdram_data_t rd_data_q [$];   // reads in flight, request order
	int          rd_due_q [$];    // cycle each read returns
	int          seed = SEED;
	int          cyc = 0;
	int          last_due = 0;
	logic        ready_next = 1'b0;
	logic        valid_next = 1'b0;
	sdram_data_t data_next = '0;

	// ====================
	// request side
	// ====================
	always @(posedge clk) begin
		int idx;
		int lat;
		int due;
		sdram_data_t word;
		cyc = cyc + 1;
		idx = int'(avl_addr);
		if (!reset_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] = ~sdram_data_t'(i);   // fill differs from the pattern
				write_count[i] = 0;
				read_count[i] = 0;
			end
			rd_data_q.delete();
			rd_due_q.delete();
			last_due = 0;
			burst_count = 0;
			ready_next = 1'b0;
			valid_next = 1'b0;
		end else begin
			valid_next = 1'b0;
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
				valid_next = 1'b1;
				data_next = rd_data_q.pop_front();
				void'(rd_due_q.pop_front());
			end
			if (avl_burstbegin)
				burst_count++;
			if (avl_write_req && avl_ready) begin
				mem[idx] = avl_wdata;
				write_count[idx]++;
			end
			if (avl_read_req && avl_ready) begin
				read_count[idx]++;
				word = mem[idx];
				if (corrupt_en && avl_addr == corrupt_addr)
					word = word ^ 64'h1;   // single bit flip
				lat = stall_en ? 1 + ($random(seed) & 3) : 1;
				due = cyc + lat;
				if (due <= last_due)
					due = last_due + 1;   // keep request order
				last_due = due;
				rd_data_q.push_back(word);
				rd_due_q.push_back(due);
			end
			ready_next = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
		end
	end

	// outputs change on the falling edge
	initial begin
		avl_ready       = 1'b0;
		avl_rdata_valid = 1'b0;
		avl_rdata       = '0;
		forever begin
			@(negedge clk);
			avl_ready       = ready_next;
			avl_rdata_valid = valid_next;
			avl_rdata       = data_next;
		end
	end

endmodule

//--- tb_cent_ctrl.sv
`timescale 1ns/1ps
// directed testbench for the controller top, with the sdram model and a pio accelerator emulation
module tb_cent_ctrl;
	import cnn_pkg::*;

	localparam int WEIGHT_BASE = 8;
	localparam int IMG_BASE    = 24;
	localparam int IFM_SIZE    = 16;
	localparam int M           = 4;
	localparam int N           = 4;
	localparam int TM          = 2;
	localparam int TN          = 2;
	localparam int SEED        = 9;
	localparam int OUT_BASE    = IMG_BASE + 3 * IFM_SIZE;
	localparam int TILE_ROUNDS = (N / TN) * (M / TM);
	// three init runs, the corrupt window and every message of every tile round
	localparam int CYCLE_LIMIT = 3 * (16 + 8 * OUT_BASE) + 4 * OUT_BASE
		+ 64 * (TILE_ROUNDS + 1) + 40;

	// pio register map of the accelerator
	localparam logic [4:0] TO_CC_ADDR   = 5'h00;
	localparam logic [4:0] FROM_CC_ADDR = 5'h10;

	logic        clk;
	logic        reset_n;
	logic        mem_cal_success;
	logic        mem_cal_fail;
	logic        host_load_done;
	logic        stall_en;
	logic        corrupt_en;
	sdram_addr_t corrupt_addr;
	pio_data_t   fpga_readdata;
	logic        avl_ready;
	logic        avl_rdata_valid;
	sdram_data_t avl_rdata;
	logic        avl_burstbegin;
	sdram_addr_t avl_addr;
	sdram_data_t avl_wdata;
	logic [7:0]  avl_be;
	logic        avl_read_req;
	logic        avl_write_req;
	logic        avl_size;
	logic [4:0]  fpga_address;
	logic        fpga_write_n;
	pio_data_t   fpga_writedata;
	logic        fpga_chipselect;
	logic        load_done;
	logic        fail;
	logic        compute_done;
	int          seed = SEED;
	int          cycles = 0;

	cent_ctrl #(
		.WEIGHT_BASE (WEIGHT_BASE),
		.IMG_BASE    (IMG_BASE),
		.IFM_SIZE    (IFM_SIZE),
		.M           (M),
		.N           (N),
		.TM          (TM),
		.TN          (TN)
	) cent_ctrl_inst (.*);

	sdram_model #(
		.DEPTH (OUT_BASE),
		.SEED  (SEED)
	) sdram_model_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, run went past %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	// ====================
	// checks
	// ====================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input sdram_data_t got, input sdram_data_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_msg(input string name, input cc_msg_t got, input cc_msg_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_pio_addr(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// bias holds its address, weights are one, channel c holds its index plus c
	function automatic sdram_data_t expected_word(input int a);
		int c;
		if (a < WEIGHT_BASE)
			return sdram_data_t'(a);
		if (a < IMG_BASE)
			return 64'd1;
		c = (a - IMG_BASE) / IFM_SIZE;
		return sdram_data_t'(a - IMG_BASE - c * IFM_SIZE + c);
	endfunction

	task automatic apply_reset;
		@(negedge clk);
		reset_n         = 1'b0;
		mem_cal_success = 1'b0;
		mem_cal_fail    = 1'b0;
		host_load_done  = 1'b0;
		fpga_readdata   = '0;
		repeat (8) @(negedge clk);
		reset_n = 1'b1;
	endtask

	task automatic check_idle(input logic loaded);
		check_bit("avl_write_req", avl_write_req, 1'b0);
		check_bit("avl_read_req", avl_read_req, 1'b0);
		check_bit("fpga_write_n", fpga_write_n, 1'b1);
		check_pio_addr("fpga_address", fpga_address, TO_CC_ADDR);
		check_bit("load_done", load_done, loaded);
		check_bit("fail", fail, 1'b0);
		check_bit("compute_done", compute_done, 1'b0);
	endtask

	task automatic check_memory;
		for (int a = 0; a < OUT_BASE; a++) begin
			check_data($sformatf("mem[%0d]", a), sdram_model_inst.mem[a], expected_word(a));
			check_count($sformatf("write_count[%0d]", a), sdram_model_inst.write_count[a], 1);
			check_count($sformatf("read_count[%0d]", a), sdram_model_inst.read_count[a], 1);
		end
		// one burst start per write and per read
		check_count("avl_burstbegin count", sdram_model_inst.burst_count, 2 * OUT_BASE);
	endtask

	// ====================
	// tests
	// ====================
	task automatic test_reset_idle;
		stall_en = 1'b0;
		corrupt_en = 1'b0;
		apply_reset;
		repeat (6) begin
			@(negedge clk);
			check_idle(1'b0);
		end
		check_bit("avl_size", avl_size, 1'b1);
		check_bit("avl_be all ones", &avl_be, 1'b1);
		mem_cal_success = 1'b1;   // calibration reports both, no start
		mem_cal_fail = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_idle(1'b0);
		end
	endtask

	task automatic run_init(input logic stalls);
		stall_en = stalls;
		corrupt_en = 1'b0;
		apply_reset;
		mem_cal_success = 1'b1;
		@(negedge clk);
		check_bit("avl_write_req", avl_write_req, 1'b1);
		while (!load_done && !fail)
			@(negedge clk);
		check_bit("fail", fail, 1'b0);
		check_memory;
		repeat (4) begin
			@(negedge clk);
			check_idle(1'b1);
		end
	endtask

	task automatic test_init_pattern;
		run_init(1'b0);
	endtask

	task automatic test_init_stalls;
		run_init(1'b1);
	endtask

	task automatic test_corrupt_word;
		stall_en = 1'b0;
		corrupt_en = 1'b1;
		corrupt_addr = sdram_addr_t'(IMG_BASE + IFM_SIZE + 3);   // inside channel 1
		apply_reset;
		mem_cal_success = 1'b1;
		while (!fail && !load_done)
			@(negedge clk);
		repeat (4 * OUT_BASE) begin
			check_bit("fail", fail, 1'b1);
			check_bit("load_done", load_done, 1'b0);
			@(negedge clk);
		end
		corrupt_en = 1'b0;
	endtask

	// acts as the accelerator, answering each echo with the next message
	task automatic test_tile_sequence;
		cc_msg_t exp_msg;
		cc_msg_t next_msg;
		int      m_t;
		int      n_t;
		int      delay;
		int      wb_rounds;
		logic    finished;
		exp_msg = MSG_START;
		next_msg = MSG_NONE;
		m_t = 0;
		n_t = 0;
		wb_rounds = 0;
		finished = 1'b0;
		check_bit("load_done", load_done, 1'b1);
		host_load_done = 1'b1;
		while (!finished) begin
			@(negedge clk);
			check_bit("compute_done", compute_done, 1'b0);
			if (!fpga_write_n) begin
				check_msg("fpga_writedata", cc_msg_t'(fpga_writedata[7:0]), exp_msg);
				check_bit("fpga_chipselect", fpga_chipselect, 1'b1);
				check_pio_addr("fpga_address", fpga_address, FROM_CC_ADDR);
				case (exp_msg)
					MSG_START:        next_msg = MSG_CHECK_IFM;
					MSG_CHECK_IFM:    next_msg = MSG_CHECK_WEIGHT;
					MSG_CHECK_WEIGHT: next_msg = MSG_CHECK_OFM;
					MSG_CHECK_OFM:    next_msg = MSG_CHECK_RESULT;
					MSG_CHECK_RESULT: next_msg = MSG_CHECK_WB;
					MSG_CHECK_WB: begin
						wb_rounds = wb_rounds + 1;
						m_t = m_t + TM;   // next output tile
						next_msg = MSG_CHECK_WEIGHT;
						if (m_t >= M) begin
							m_t = 0;
							n_t = n_t + TN;
							next_msg = MSG_CHECK_IFM;
						end
						finished = (n_t >= N);
					end
					default: abort_run("accelerator emulation reached an unknown message");
				endcase
				exp_msg = next_msg;
				if (!finished) begin
					delay = $random(seed) & 3;
					repeat (delay) begin
						@(negedge clk);
						check_bit("fpga_write_n", fpga_write_n, 1'b1);
						check_pio_addr("fpga_address", fpga_address, TO_CC_ADDR);
					end
					fpga_readdata = pio_data_t'(next_msg);
				end
			end
		end
		check_count("check_wb rounds", wb_rounds, TILE_ROUNDS);
		while (!compute_done) begin
			@(negedge clk);
			check_bit("fpga_write_n", fpga_write_n, 1'b1);
		end
		repeat (4) begin
			@(negedge clk);
			check_bit("compute_done", compute_done, 1'b1);
			check_bit("fpga_write_n", fpga_write_n, 1'b1);
		end
	endtask

	initial begin
		reset_n         = 1'b0;
		mem_cal_success = 1'b0;
		mem_cal_fail    = 1'b0;
		host_load_done  = 1'b0;
		stall_en        = 1'b0;
		corrupt_en      = 1'b0;
		corrupt_addr    = '0;
		fpga_readdata   = '0;
		test_reset_idle;
		test_init_pattern;
		test_corrupt_word;
		test_init_stalls;
		test_tile_sequence;
		$display("** PASS **");
		$finish;
	end

endmodule

//--- tile_sequencer.sv
`timescale 1ns/1ps
// pio message exchange with the accelerator and the m/n tile counters that end in compute done
module tile_sequencer
	import cnn_pkg::*;
#(
	parameter int M  = 4,
	parameter int N  = 4,
	parameter int TM = 2,
	parameter int TN = 2
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        load_done,
	input  logic        host_load_done,
	input  pio_data_t   fpga_readdata,     // to-controller pio register
	output logic [4:0]  fpga_address,
	output logic        fpga_write_n,
	output pio_data_t   fpga_writedata,    // from-controller pio register
	output logic        fpga_chipselect,
	output logic        compute_done
);

	// pio data register offsets
	localparam logic [4:0] TO_CC_OFFSET   = 5'h00;
	localparam logic [4:0] FROM_CC_OFFSET = 5'h10;

	localparam tile_count_t M_T  = tile_count_t'(M);
	localparam tile_count_t N_T  = tile_count_t'(N);
	localparam tile_count_t TM_T = tile_count_t'(TM);
	localparam tile_count_t TN_T = tile_count_t'(TN);

	cc_msg_t     to_cc_loc;    // accelerator message on the bus this cycle
	cc_msg_t     to_cc;        // latest nonzero accelerator message
	cc_msg_t     from_cc;      // last message written back
	cc_msg_t     msg;          // message we wait for
	logic        started;
	logic        write_n;
	logic        compute_start;
	logic        msg_match;
	logic        msg_capture;
	logic        wb_entry;
	tile_count_t m;
	tile_count_t n;

	assign to_cc_loc     = cc_msg_t'(fpga_readdata[7:0]);
	assign compute_start = load_done && host_load_done;
	assign msg_match     = (to_cc == msg);

	// a new nonzero message replaces the stored one, except while echoing
	assign msg_capture = compute_start && started && !msg_match
		&& (to_cc_loc != MSG_NONE) && (to_cc_loc != to_cc);
	assign wb_entry = msg_capture && (to_cc_loc == MSG_CHECK_WB);

	// ====================
	// pio outputs
	// ====================
	assign fpga_write_n    = write_n;
	assign fpga_writedata  = {24'b0, from_cc};
	assign fpga_address    = write_n ? TO_CC_OFFSET : FROM_CC_OFFSET;
	assign fpga_chipselect = 1'b1;

	// ====================
	// message exchange
	// ====================
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			to_cc   <= MSG_NONE;
			from_cc <= MSG_NONE;
			msg     <= MSG_NONE;
			started <= 1'b0;
			write_n <= 1'b1;
		end else if (compute_start) begin
			if (!started) begin
				from_cc <= MSG_START;   // kick off the accelerator
				write_n <= 1'b0;
				msg     <= MSG_CHECK_IFM;
				started <= 1'b1;
			end else begin
				if (msg_match) begin
					from_cc <= msg;       // echo back
					write_n <= 1'b0;
				end else begin
					write_n <= 1'b1;
					if (msg_capture)
						to_cc <= to_cc_loc;
				end

				// next expected message, first match wins
				if (m >= M_T)
					msg <= MSG_CHECK_IFM;       // new input tile
				else if (to_cc == MSG_CHECK_WB && m != '0)
					msg <= MSG_CHECK_WEIGHT;    // next weight tile
				else if (to_cc == MSG_CHECK_IFM)
					msg <= MSG_CHECK_WEIGHT;
				else if (to_cc == MSG_CHECK_WEIGHT)
					msg <= MSG_CHECK_OFM;
				else if (to_cc == MSG_CHECK_OFM)
					msg <= MSG_CHECK_RESULT;
				else if (to_cc == MSG_CHECK_RESULT)
					msg <= MSG_CHECK_WB;
			end
		end
	end

	// ====================
	// tile counters
	// ====================
	// m steps on the cycle check_wb is stored, so the message rules
	// already see the new m when the write-back is echoed
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			m            <= '0;
			n            <= '0;
			compute_done <= 1'b0;
		end else if (n >= N_T) begin
			compute_done <= 1'b1;
		end else if (m >= M_T) begin
			n <= n + TN_T;   // output maps done for this input tile
			m <= '0;
		end else if (wb_entry) begin
			m <= m + TM_T;
		end
	end

endmodule
